// File: matmul_pkg.sv
package matmul_pkg;

  //////////////////////////////////////////////////
  // Widths and array geometry
  //////////////////////////////////////////////////

  // One matrix element, signed two's complement
  localparam int DATA_WIDTH = 8;

  // Memory address and address stride widths
  localparam int ADDR_WIDTH   = 10;
  localparam int STRIDE_WIDTH = 8;

  // Rows and columns of the square tile
  localparam int MAT_SIZE = 4;

  // Register stages in a cell from operand in to sum updated
  localparam int MAC_LATENCY = 3;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  typedef logic signed [DATA_WIDTH-1:0]   data_t;
  typedef logic signed [2*DATA_WIDTH-1:0] prod_t;
  typedef logic [ADDR_WIDTH-1:0]          addr_t;
  typedef logic [STRIDE_WIDTH-1:0]        stride_t;
  typedef logic [7:0]                     count_t;

  // Sequencer states of the control module
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FEED,
    ST_DRAIN,
    ST_HOLD
  } ctrl_state_t;

endpackage

// File: matmul_ctrl.sv
`timescale 1ns/1ps

module matmul_ctrl #(
  parameter int MAT_SIZE = matmul_pkg::MAT_SIZE
) (
  input  logic clk,
  input  logic reset,
  input  logic i_start,
  input  logic i_drain_done,
  output logic o_feed_en,
  output logic o_latch,
  output logic o_clear,
  output logic o_done
);

  // Memories answer one cycle after the address
  localparam int MEM_LATENCY = 1;

  // Extra cycles that lane skew plus grid travel add to the far corner
  localparam int SKEW_CYCLES = 2 * (MAT_SIZE - 1);

  // Counter value of the cycle after the bottom-right cell took its last product.
  // The last feed cycle is at count MAT_SIZE-1
  localparam int LATCH_CNT = (MAT_SIZE - 1) + MEM_LATENCY + SKEW_CYCLES +
                             matmul_pkg::MAC_LATENCY;

  matmul_pkg::ctrl_state_t state;
  matmul_pkg::count_t      cnt;

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  // A low start level aborts whatever is running and parks the FSM in idle
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      state  <= matmul_pkg::ST_IDLE;
      cnt    <= '0;
      o_done <= 1'b0;
    end else begin
      // Done is a single-cycle pulse unless the drain finishes right now
      o_done <= 1'b0;
      case (state)
        matmul_pkg::ST_IDLE: begin
          // Start seen high here, feeding opens on the next cycle
          state <= matmul_pkg::ST_FEED;
          cnt   <= '0;
        end
        matmul_pkg::ST_FEED: begin
          // The counter keeps running past the feed window until the latch point
          cnt <= cnt + matmul_pkg::count_t'(1);
          if (o_latch) begin
            state <= matmul_pkg::ST_DRAIN;
          end
        end
        matmul_pkg::ST_DRAIN: begin
          if (i_drain_done) begin
            o_done <= 1'b1;
            state  <= matmul_pkg::ST_HOLD;
          end
        end
        matmul_pkg::ST_HOLD: begin
          // Nothing to do until start falls
          state <= matmul_pkg::ST_HOLD;
        end
        default: begin
          state <= matmul_pkg::ST_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Decoded strobes
  //////////////////////////////////////////////////

  // Feed window covers counts 0 to MAT_SIZE-1, one column of A and row of B each
  assign o_feed_en = (state == matmul_pkg::ST_FEED) &&
                     (cnt < matmul_pkg::count_t'(MAT_SIZE));

  // Result capture strobe for the drain
  assign o_latch = (state == matmul_pkg::ST_FEED) &&
                   (cnt == matmul_pkg::count_t'(LATCH_CNT));

  // The datapath is held clear for as long as start is low
  assign o_clear = !i_start;

endmodule

// File: operand_feeder.sv
`timescale 1ns/1ps

module operand_feeder #(
  parameter int MAT_SIZE = matmul_pkg::MAT_SIZE
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     i_clear,
  input  logic                                     i_feed_en,
  input  matmul_pkg::addr_t                        i_base,
  input  matmul_pkg::stride_t                      i_stride,
  input  logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0] i_mem_data,
  output matmul_pkg::addr_t                        o_addr,
  output logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0] o_lanes
);

  localparam int DW = matmul_pkg::DATA_WIDTH;

  matmul_pkg::addr_t addr_q;
  logic              data_valid;

  //////////////////////////////////////////////////
  // Address generation and read qualification
  //////////////////////////////////////////////////

  // While clear the pointer sits at the base, so the first feed cycle
  // presents the base address itself
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      addr_q     <= i_base;
      data_valid <= 1'b0;
    end else begin
      // Read data shows up one cycle behind its address
      data_valid <= i_feed_en;
      if (i_feed_en) begin
        addr_q <= addr_q + matmul_pkg::addr_t'(i_stride);
      end
    end
  end

  assign o_addr = addr_q;

  //////////////////////////////////////////////////
  // Lane skew
  //////////////////////////////////////////////////

  // Lane i is held back i extra cycles so the operands hit the grid as a diagonal
  for (genvar lane = 0; lane < MAT_SIZE; lane++) begin : g_lane
    matmul_pkg::data_t lane_data;

    // Bus contents outside the read window are not operands, feed zeros instead
    assign lane_data = data_valid ? i_mem_data[lane*DW +: DW] : '0;

    if (lane == 0) begin : g_direct
      assign o_lanes[lane*DW +: DW] = lane_data;
    end else begin : g_skew
      matmul_pkg::data_t skew_q [lane];

      always_ff @(posedge clk) begin
        if (reset || i_clear) begin
          for (int k = 0; k < lane; k++) begin
            skew_q[k] <= '0;
          end
        end else begin
          skew_q[0] <= lane_data;
          for (int k = 1; k < lane; k++) begin
            skew_q[k] <= skew_q[k-1];
          end
        end
      end

      // Tail of the chain
      assign o_lanes[lane*DW +: DW] = skew_q[lane-1];
    end
  end

endmodule

// File: processing_element.sv
`timescale 1ns/1ps

module processing_element (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_clear,
  input  matmul_pkg::data_t i_a,
  input  matmul_pkg::data_t i_b,
  output matmul_pkg::data_t o_a,
  output matmul_pkg::data_t o_b,
  output matmul_pkg::data_t o_sum
);

  // Signed element range, held at product width for the compare
  localparam matmul_pkg::prod_t PROD_MAX =
    matmul_pkg::prod_t'((2 ** (matmul_pkg::DATA_WIDTH - 1)) - 1);
  localparam matmul_pkg::prod_t PROD_MIN =
    matmul_pkg::prod_t'(-(2 ** (matmul_pkg::DATA_WIDTH - 1)));

  matmul_pkg::data_t mul_a;
  matmul_pkg::data_t mul_b;
  matmul_pkg::prod_t prod_q;
  matmul_pkg::data_t prod_sat;

  //////////////////////////////////////////////////
  // Operand stage
  //////////////////////////////////////////////////

  // Stage 1 of 3: forward copies go right and down, the other copy feeds the multiplier
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_a   <= '0;
      o_b   <= '0;
      mul_a <= '0;
      mul_b <= '0;
    end else begin
      o_a   <= i_a;
      o_b   <= i_b;
      mul_a <= i_a;
      mul_b <= i_b;
    end
  end

  // Stage 2 keeps the full signed product
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      prod_q <= '0;
    end else begin
      prod_q <= mul_a * mul_b;
    end
  end

  //////////////////////////////////////////////////
  // Saturate and accumulate
  //////////////////////////////////////////////////

  // Clamp the product into the element range before it reaches the adder
  always_comb begin
    if (prod_q > PROD_MAX) begin
      prod_sat = matmul_pkg::data_t'(PROD_MAX);
    end else if (prod_q < PROD_MIN) begin
      prod_sat = matmul_pkg::data_t'(PROD_MIN);
    end else begin
      prod_sat = prod_q[matmul_pkg::DATA_WIDTH-1:0];
    end
  end

  // Stage 3, the running sum simply wraps on overflow
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_sum <= '0;
    end else begin
      o_sum <= o_sum + prod_sat;
    end
  end

endmodule

// File: pe_array.sv
`timescale 1ns/1ps

module pe_array #(
  parameter int MAT_SIZE = matmul_pkg::MAT_SIZE
) (
  input  logic                                              clk,
  input  logic                                              reset,
  input  logic                                              i_clear,
  input  logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0]          i_a_lanes,
  input  logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0]          i_b_lanes,
  output logic [MAT_SIZE*MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0] o_sums
);

  localparam int DW = matmul_pkg::DATA_WIDTH;

  // Registered operand outputs of every cell.
  // The right column and bottom row outputs go nowhere
  matmul_pkg::data_t a_fwd [MAT_SIZE][MAT_SIZE];
  matmul_pkg::data_t b_fwd [MAT_SIZE][MAT_SIZE];

  //////////////////////////////////////////////////
  // Cell grid
  //////////////////////////////////////////////////

  for (genvar row = 0; row < MAT_SIZE; row++) begin : g_row
    for (genvar col = 0; col < MAT_SIZE; col++) begin : g_col
      matmul_pkg::data_t a_in;
      matmul_pkg::data_t b_in;

      // A flows left to right, the left column takes the A lane of its row
      if (col == 0) begin : g_a_edge
        assign a_in = i_a_lanes[row*DW +: DW];
      end else begin : g_a_link
        assign a_in = a_fwd[row][col-1];
      end

      // B flows top to bottom, the top row takes the B lane of its column
      if (row == 0) begin : g_b_edge
        assign b_in = i_b_lanes[col*DW +: DW];
      end else begin : g_b_link
        assign b_in = b_fwd[row-1][col];
      end

      // Sums are packed row-major
      processing_element u_pe (
        .clk     (clk),
        .reset   (reset),
        .i_clear (i_clear),
        .i_a     (a_in),
        .i_b     (b_in),
        .o_a     (a_fwd[row][col]),
        .o_b     (b_fwd[row][col]),
        .o_sum   (o_sums[(row*MAT_SIZE+col)*DW +: DW])
      );
    end
  end

endmodule

// File: result_drain.sv
`timescale 1ns/1ps

module result_drain #(
  parameter int MAT_SIZE = matmul_pkg::MAT_SIZE
) (
  input  logic                                              clk,
  input  logic                                              reset,
  input  logic                                              i_clear,
  input  logic                                              i_latch,
  input  logic [MAT_SIZE*MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0] i_sums,
  input  matmul_pkg::addr_t                                 i_base,
  input  matmul_pkg::stride_t                               i_stride,
  output logic                                              o_c_valid,
  output matmul_pkg::addr_t                                 o_c_addr,
  output logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0]          o_c_data,
  output logic                                              o_drain_done
);

  localparam int DW    = matmul_pkg::DATA_WIDTH;
  localparam int COL_W = (MAT_SIZE > 1) ? $clog2(MAT_SIZE) : 1;
  localparam logic [COL_W-1:0] LAST_COL = COL_W'(MAT_SIZE - 1);

  logic [MAT_SIZE*MAT_SIZE*DW-1:0] cap_q;
  logic [COL_W-1:0]                col_q;

  //////////////////////////////////////////////////
  // Result capture
  //////////////////////////////////////////////////

  // Snapshot of the whole C matrix, the grid is free to clear after this
  always_ff @(posedge clk) begin
    if (i_latch) begin
      cap_q <= i_sums;
    end
  end

  //////////////////////////////////////////////////
  // Column walk
  //////////////////////////////////////////////////

  // One column per cycle starting right after the latch
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_c_valid <= 1'b0;
      col_q     <= '0;
      o_c_addr  <= i_base;
    end else if (i_latch) begin
      o_c_valid <= 1'b1;
      col_q     <= '0;
      o_c_addr  <= i_base;
    end else if (o_c_valid) begin
      o_c_addr <= o_c_addr + matmul_pkg::addr_t'(i_stride);
      if (col_q == LAST_COL) begin
        o_c_valid <= 1'b0;
        col_q     <= '0;
      end else begin
        col_q <= col_q + COL_W'(1);
      end
    end
  end

  // Flagged together with the final write
  assign o_drain_done = o_c_valid && (col_q == LAST_COL);

  // Gather column col_q, row i lands in lane i
  always_comb begin
    for (int row = 0; row < MAT_SIZE; row++) begin
      o_c_data[row*DW +: DW] = cap_q[(row*MAT_SIZE + int'(col_q))*DW +: DW];
    end
  end

endmodule

// File: matmul_top.sv
`timescale 1ns/1ps

module matmul_top #(
  parameter int MAT_SIZE = matmul_pkg::MAT_SIZE
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     i_start,
  input  matmul_pkg::addr_t                        i_a_base,
  input  matmul_pkg::addr_t                        i_b_base,
  input  matmul_pkg::addr_t                        i_c_base,
  input  matmul_pkg::stride_t                      i_a_stride,
  input  matmul_pkg::stride_t                      i_b_stride,
  input  matmul_pkg::stride_t                      i_c_stride,
  input  logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0] i_a_data,
  input  logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0] i_b_data,
  output matmul_pkg::addr_t                        o_a_addr,
  output matmul_pkg::addr_t                        o_b_addr,
  output matmul_pkg::addr_t                        o_c_addr,
  output logic                                     o_c_valid,
  output logic [MAT_SIZE*matmul_pkg::DATA_WIDTH-1:0] o_c_data,
  output logic                                     o_done
);

  localparam int DW = matmul_pkg::DATA_WIDTH;

  logic                            feed_en;
  logic                            clear;
  logic                            latch;
  logic                            drain_done;
  logic [MAT_SIZE*DW-1:0]          a_lanes;
  logic [MAT_SIZE*DW-1:0]          b_lanes;
  logic [MAT_SIZE*MAT_SIZE*DW-1:0] sums;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  matmul_ctrl #(.MAT_SIZE(MAT_SIZE)) u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .i_start      (i_start),
    .i_drain_done (drain_done),
    .o_feed_en    (feed_en),
    .o_latch      (latch),
    .o_clear      (clear),
    .o_done       (o_done)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // A words are columns of A, lane i is row i
  operand_feeder #(.MAT_SIZE(MAT_SIZE)) u_feed_a (
    .clk (clk), .reset (reset), .i_clear (clear), .i_feed_en (feed_en),
    .i_base (i_a_base), .i_stride (i_a_stride), .i_mem_data (i_a_data),
    .o_addr (o_a_addr), .o_lanes (a_lanes)
  );

  // B words are rows of B, lane j is column j
  operand_feeder #(.MAT_SIZE(MAT_SIZE)) u_feed_b (
    .clk (clk), .reset (reset), .i_clear (clear), .i_feed_en (feed_en),
    .i_base (i_b_base), .i_stride (i_b_stride), .i_mem_data (i_b_data),
    .o_addr (o_b_addr), .o_lanes (b_lanes)
  );

  pe_array #(.MAT_SIZE(MAT_SIZE)) u_array (
    .clk       (clk),
    .reset     (reset),
    .i_clear   (clear),
    .i_a_lanes (a_lanes),
    .i_b_lanes (b_lanes),
    .o_sums    (sums)
  );

  result_drain #(.MAT_SIZE(MAT_SIZE)) u_drain (
    .clk (clk), .reset (reset), .i_clear (clear), .i_latch (latch), .i_sums (sums),
    .i_base (i_c_base), .i_stride (i_c_stride),
    .o_c_valid (o_c_valid), .o_c_addr (o_c_addr), .o_c_data (o_c_data),
    .o_drain_done (drain_done)
  );

endmodule

// File: tb_matmul.sv
`timescale 1ns/1ps

module tb_matmul;

  localparam int MAT_SIZE    = matmul_pkg::MAT_SIZE;
  localparam int DW          = matmul_pkg::DATA_WIDTH;
  localparam int CLK_PERIOD  = 20;
  localparam int N_RANDOM    = 20;
  localparam int N_EXTREME   = 4;
  localparam int N_ABORT     = 3;
  // An aborted run and its restart count as two operations
  localparam int NUM_OPS     = N_RANDOM + N_EXTREME + 2 * N_ABORT;
  localparam int DONE_BOUND  = 8 * MAT_SIZE + matmul_pkg::MAC_LATENCY + 4;
  localparam int WATCHDOG_CY = NUM_OPS * 40 + 30;

  logic clk;
  logic reset;
  logic i_start;
  matmul_pkg::addr_t   a_base, b_base, c_base;
  matmul_pkg::stride_t a_stride, b_stride, c_stride;
  logic [MAT_SIZE*DW-1:0] a_data, b_data, c_data;
  matmul_pkg::addr_t   a_addr, b_addr, c_addr;
  logic c_valid;
  logic done;

  // Operand memories hold one lane vector per word and c_mem records the C writes
  logic [MAT_SIZE*DW-1:0] a_mem [2**matmul_pkg::ADDR_WIDTH];
  logic [MAT_SIZE*DW-1:0] b_mem [2**matmul_pkg::ADDR_WIDTH];
  logic [MAT_SIZE*DW-1:0] c_mem [2**matmul_pkg::ADDR_WIDTH];

  // Matrices of the current job and its reference result c_exp
  matmul_pkg::data_t a_m   [MAT_SIZE][MAT_SIZE];
  matmul_pkg::data_t b_m   [MAT_SIZE][MAT_SIZE];
  matmul_pkg::data_t c_exp [MAT_SIZE][MAT_SIZE];
  logic [31:0] rng;

  matmul_top #(.MAT_SIZE(MAT_SIZE)) dut (
    .clk (clk), .reset (reset), .i_start (i_start),
    .i_a_base (a_base), .i_b_base (b_base), .i_c_base (c_base),
    .i_a_stride (a_stride), .i_b_stride (b_stride), .i_c_stride (c_stride),
    .i_a_data (a_data), .i_b_data (b_data),
    .o_a_addr (a_addr), .o_b_addr (b_addr), .o_c_addr (c_addr),
    .o_c_valid (c_valid), .o_c_data (c_data), .o_done (done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Both memories answer one cycle after the address
  always @(posedge clk) begin
    a_data <= a_mem[a_addr];
    b_data <= b_mem[b_addr];
  end

  initial begin
    #(WATCHDOG_CY * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish in the allowed time");
    $display("*** FAILED ***");
    $fatal(1);
  end

  //////////////////////////////////////////////////
  // Helpers and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // A stride of exactly 1 in about a quarter of the draws, else 1 to 255
  function automatic matmul_pkg::stride_t draw_stride();
    logic [31:0] r;
    r = next_rand();
    if (r[1:0] == 2'd0) return matmul_pkg::stride_t'(1);
    return matmul_pkg::stride_t'(1 + (r >> 2) % 255);
  endfunction

  // Full product clamped to the signed element range
  function automatic matmul_pkg::data_t sat_product(matmul_pkg::data_t a, matmul_pkg::data_t b);
    int p;
    p = int'(a) * int'(b);
    if (p > 2**(DW-1) - 1) return matmul_pkg::data_t'(2**(DW-1) - 1);
    if (p < -(2**(DW-1))) return matmul_pkg::data_t'(-(2**(DW-1)));
    return matmul_pkg::data_t'(p);
  endfunction

  function automatic logic [MAT_SIZE*DW-1:0] model_column(int j);
    logic [MAT_SIZE*DW-1:0] w;
    for (int i = 0; i < MAT_SIZE; i++) w[i*DW +: DW] = c_exp[i][j];
    return w;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  // Draws new matrices, bases and strides, loads the memories and computes the model
  task automatic load_job(input bit extreme);
    logic [MAT_SIZE*DW-1:0] wa, wb;
    logic [31:0] r;
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int k = 0; k < MAT_SIZE; k++) begin
        r = next_rand();
        // Extreme jobs use only -128 and 127 to hit saturation and wraparound
        a_m[i][k] = extreme ? (r[0] ? 8'sh80 : 8'sh7f) : matmul_pkg::data_t'(r[7:0]);
        b_m[i][k] = extreme ? (r[9] ? 8'sh80 : 8'sh7f) : matmul_pkg::data_t'(r[15:8]);
      end
    end
    a_base <= matmul_pkg::addr_t'(next_rand());
    b_base <= matmul_pkg::addr_t'(next_rand());
    c_base <= matmul_pkg::addr_t'(next_rand());
    a_stride <= draw_stride();
    b_stride <= draw_stride();
    c_stride <= draw_stride();
    @(posedge clk);
    // Word k of A is column k, word k of B is row k
    for (int k = 0; k < MAT_SIZE; k++) begin
      for (int i = 0; i < MAT_SIZE; i++) begin
        wa[i*DW +: DW] = a_m[i][k];
        wb[i*DW +: DW] = b_m[k][i];
      end
      a_mem[a_base + matmul_pkg::addr_t'(k) * matmul_pkg::addr_t'(a_stride)] = wa;
      b_mem[b_base + matmul_pkg::addr_t'(k) * matmul_pkg::addr_t'(b_stride)] = wb;
    end
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        c_exp[i][j] = '0;
        for (int k = 0; k < MAT_SIZE; k++) begin
          c_exp[i][j] = c_exp[i][j] + sat_product(a_m[i][k], b_m[k][j]);
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Operations
  //////////////////////////////////////////////////

  task automatic run_op();
    int writes;
    int cycles;
    bit seen_done;
    matmul_pkg::addr_t exp_addr;
    writes = 0;
    cycles = 0;
    seen_done = 1'b0;
    @(posedge clk);
    i_start <= 1'b1;
    while (!seen_done) begin
      @(negedge clk);
      cycles++;
      if (c_valid) begin
        if (writes >= MAT_SIZE) begin
          $display("More C writes than matrix columns in one operation");
          $display("*** FAILED ***");
          $fatal(1);
        end
        exp_addr = c_base + matmul_pkg::addr_t'(writes) * matmul_pkg::addr_t'(c_stride);
        check_value("o_c_addr", exp_addr, c_addr);
        // The write record is compared with the model once o_done arrives
        c_mem[c_addr] = c_data;
        writes++;
      end
      if (done) begin
        // Done must come after the final write
        check_value("C write count at o_done", MAT_SIZE, writes);
        seen_done = 1'b1;
      end else if (cycles > DONE_BOUND) begin
        $display("o_done did not arrive within the expected number of cycles");
        $display("*** FAILED ***");
        $fatal(1);
      end
    end
    for (int j = 0; j < MAT_SIZE; j++) begin
      exp_addr = c_base + matmul_pkg::addr_t'(j) * matmul_pkg::addr_t'(c_stride);
      check_value("c_mem", model_column(j), c_mem[exp_addr]);
    end
    // Start still high, so the tile must stay quiet
    repeat (4) begin
      @(negedge clk);
      check_value("o_done", 0, done);
      check_value("o_c_valid", 0, c_valid);
    end
    @(posedge clk);
    i_start <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic abort_op(input int run_cycles);
    @(posedge clk);
    i_start <= 1'b1;
    repeat (run_cycles) @(posedge clk);
    i_start <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  initial begin
    rng      = 32'd83;
    reset    = 1'b1;
    i_start  = 1'b0;
    a_base   = '0;
    b_base   = '0;
    c_base   = '0;
    a_stride = 8'd1;
    b_stride = 8'd1;
    c_stride = 8'd1;
    a_data   = '0;
    b_data   = '0;
    for (int n = 0; n < 2**matmul_pkg::ADDR_WIDTH; n++) begin
      a_mem[n] = {n[9:0], ~n[9:0], n[9:0], 2'b01};
      b_mem[n] = {~n[9:0], n[9:0], ~n[9:0], 2'b10};
      c_mem[n] = '0;
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    // Idle tile after reset
    repeat (6) begin
      @(negedge clk);
      check_value("o_done", 0, done);
      check_value("o_c_valid", 0, c_valid);
    end
    @(posedge clk);
    for (int n = 0; n < N_RANDOM; n++) begin
      load_job(1'b0);
      run_op();
    end
    for (int n = 0; n < N_EXTREME; n++) begin
      load_job(1'b1);
      run_op();
    end
    // Aborts land anywhere from the feed window into the drain
    for (int n = 0; n < N_ABORT; n++) begin
      load_job(1'b0);
      abort_op(2 + next_rand() % 17);
      load_job(1'b0);
      run_op();
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: project.f
matmul_pkg.sv
matmul_ctrl.sv
operand_feeder.sv
processing_element.sv
pe_array.sv
result_drain.sv
matmul_top.sv
tb_matmul.sv
